/* include/i8080_cfg.svh */
`ifndef I8080_CFG_SVH
`define I8080_CFG_SVH

// Program memory size in bytes
`define I8080_PROG_DEPTH 256

// Data RAM size in bytes, addressed by the low byte of a pair
`define I8080_DATA_DEPTH 256

// PC after reset and after start
`define I8080_RESET_PC 16'h0000

`endif

/* rtl/i8080_pkg.sv */
package i8080_pkg;

  // Operand path chosen by the decoder
  typedef enum logic [1:0] {
    ALU_SRC_REG    = 2'b00, // Register operation
    ALU_SRC_IMM    = 2'b01, // Immediate byte or word
    ALU_SRC_MOVE   = 2'b10, // Move, memory or rotate
    ALU_SRC_INCDEC = 2'b11  // INR, DCR, INX, DCX
  } alu_src_t;

  // Opcode bits 5:3 of the arithmetic group
  typedef enum logic [2:0] {
    ALU_ADD = 3'b000,
    ALU_ADC = 3'b001,
    ALU_SUB = 3'b010,
    ALU_SBB = 3'b011,
    ALU_ANA = 3'b100,
    ALU_XRA = 3'b101,
    ALU_ORA = 3'b110,
    ALU_CMP = 3'b111
  } alu_op_t;

  typedef struct packed {
    logic z;  // Zero
    logic cy; // Carry or borrow
  } flags_t;

  // One entry of the store stream
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
  } store_t;

endpackage

/* rtl/control.sv */
module control (
  input  logic                instr_ready,
  input  logic [7:0]          instr,
  input  logic [1:0]          num_bytes, // Length is resolved in fetch
  output logic                halt,
  output logic                load_en,
  output logic                store_en,
  output logic                imm_pass_thru,
  output logic                rp_en,
  output logic                reg_write_en,
  output logic                flag_write_en,
  output logic                pchl,
  output i8080_pkg::alu_src_t alu_source,
  output logic [2:0]          alu_op
);

  always_comb begin
    halt          = 1'b0;
    load_en       = 1'b0;
    store_en      = 1'b0;
    imm_pass_thru = 1'b0;
    rp_en         = 1'b0;
    reg_write_en  = 1'b0;
    flag_write_en = 1'b0;
    pchl          = 1'b0;
    alu_source    = i8080_pkg::ALU_SRC_REG;
    alu_op        = 3'b000;

    if (instr_ready) begin
      alu_op = instr[5:3];
      case (instr[7:6])
        2'b00: begin
          if (!instr[2]) begin
            if (instr[1:0] != 2'b00) begin // LXI, DAD, STAX, LDAX, INX, DCX
              rp_en = 1'b1;
              case (instr[1:0])
                2'b01: begin
                  reg_write_en = 1'b1;
                  if (instr[3]) begin // DAD
                    flag_write_en = 1'b1;
                  end else begin // LXI
                    imm_pass_thru = 1'b1;
                    alu_source    = i8080_pkg::ALU_SRC_IMM;
                  end
                end
                2'b10: begin
                  alu_source = i8080_pkg::ALU_SRC_MOVE;
                  if (instr[3]) begin // LDAX
                    load_en       = 1'b1;
                    reg_write_en  = 1'b1;
                    flag_write_en = 1'b1;
                  end else begin
                    store_en = 1'b1; // STAX
                  end
                end
                default: begin // INX, DCX
                  alu_source   = i8080_pkg::ALU_SRC_INCDEC;
                  reg_write_en = 1'b1;
                end
              endcase
            end
          end else if (!instr[1]) begin // INR, DCR
            alu_source    = i8080_pkg::ALU_SRC_INCDEC;
            reg_write_en  = 1'b1;
            flag_write_en = 1'b1;
          end else if (!instr[0]) begin // MVI
            imm_pass_thru = 1'b1;
            alu_source    = i8080_pkg::ALU_SRC_IMM;
            reg_write_en  = 1'b1;
          end else if (!instr[5]) begin // RLC, RRC, RAL, RAR
            alu_source    = i8080_pkg::ALU_SRC_MOVE;
            reg_write_en  = 1'b1;
            flag_write_en = 1'b1;
          end else if (instr[4]) begin
            flag_write_en = 1'b1; // STC, CMC
          end else begin
            reg_write_en = 1'b1; // DAA, CMA
          end
        end
        2'b01: begin
          if (instr[5:0] == 6'b110110) begin
            halt = 1'b1;
          end else begin // MOV
            alu_source   = i8080_pkg::ALU_SRC_MOVE;
            reg_write_en = 1'b1;
          end
        end
        2'b10: begin // Register ALU group
          flag_write_en = 1'b1;
          reg_write_en  = (instr[5:3] != 3'b111); // CMP keeps A
        end
        default: begin
          if (instr[2:0] == 3'b110) begin // Immediate ALU group
            imm_pass_thru = 1'b1;
            alu_source    = i8080_pkg::ALU_SRC_IMM;
            flag_write_en = 1'b1;
            reg_write_en  = (instr[5:3] != 3'b111);
          end else if (instr[2:1] == 2'b01) begin // JMP and Jcc
            imm_pass_thru = 1'b1;
            alu_source    = i8080_pkg::ALU_SRC_IMM;
          end else if (instr[5:0] == 6'b101001) begin
            imm_pass_thru = 1'b1;
            alu_source    = i8080_pkg::ALU_SRC_IMM;
            pchl          = 1'b1;
          end
        end
      endcase
    end
  end

endmodule

/* rtl/instr_fetch.sv */
`include "i8080_cfg.svh"

module instr_fetch (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  logic              prog_valid,
  input  logic [7:0]        prog_data,
  output logic              prog_ready,
  input  logic              halt,
  input  logic              mem_busy,
  input  i8080_pkg::flags_t flags,
  output logic [7:0]        instr,
  output logic [7:0]        imm_lo,
  output logic [7:0]        imm_hi,
  output logic              instr_ready,
  output logic [1:0]        num_bytes,
  output logic              halted
);

  localparam int ADDR_W = $clog2(`I8080_PROG_DEPTH);

  typedef enum logic [1:0] {S_IDLE, S_FETCH, S_EXEC} state_t;

  function automatic logic [1:0] len_of(input logic [7:0] op);
    logic [1:0] len;
    len = 2'd1;
    if (op[7:6] == 2'b00 && op[3:0] == 4'b0001) len = 2'd3; // LXI
    else if (op[2:0] == 3'b110 && (op[7:6] == 2'b00 || op[7:6] == 2'b11)) len = 2'd2;
    else if (op[7:6] == 2'b11 && op[2:1] == 2'b01) len = 2'd3; // Jumps
    return len;
  endfunction

  logic [7:0]        prog_mem [`I8080_PROG_DEPTH];
  state_t            state;
  logic [15:0]       pc;
  logic [1:0]        byte_idx;
  logic [ADDR_W-1:0] load_addr;
  logic              halted_q;
  logic [7:0]        rd_byte;
  logic [1:0]        fetch_len;
  logic              take_jump;

  assign rd_byte     = prog_mem[pc[ADDR_W-1:0]];
  assign num_bytes   = len_of(instr);
  assign fetch_len   = (byte_idx == 2'd0) ? len_of(rd_byte) : num_bytes; // First byte sets it
  assign prog_ready  = (state == S_IDLE);
  assign instr_ready = (state == S_EXEC);
  assign halted      = halted_q | halt; // Rises in the HLT execute cycle

  always_comb begin
    take_jump = 1'b0;
    if (instr[7:6] == 2'b11 && instr[2:0] == 3'b011) begin
      take_jump = 1'b1;
    end else if (instr[7:6] == 2'b11 && instr[2:0] == 3'b010) begin
      case (instr[5:3])
        3'b000:  take_jump = !flags.z;  // JNZ
        3'b001:  take_jump = flags.z;   // JZ
        3'b010:  take_jump = !flags.cy; // JNC
        3'b011:  take_jump = flags.cy;  // JC
        default: take_jump = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (prog_valid && prog_ready) prog_mem[load_addr] <= prog_data;
    if (state == S_FETCH) begin
      case (byte_idx)
        2'd0:    instr  <= rd_byte;
        2'd1:    imm_lo <= rd_byte;
        default: imm_hi <= rd_byte;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      pc        <= `I8080_RESET_PC;
      byte_idx  <= 2'd0;
      load_addr <= '0;
      halted_q  <= 1'b0;
    end else if (start) begin
      state     <= S_FETCH;
      pc        <= `I8080_RESET_PC;
      byte_idx  <= 2'd0;
      load_addr <= '0; // Next load starts at 0 again
      halted_q  <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (prog_valid) load_addr <= load_addr + 1'b1;
        end
        S_FETCH: begin
          pc       <= pc + 16'd1;
          byte_idx <= byte_idx + 2'd1;
          if (byte_idx == fetch_len - 2'd1) begin
            state    <= S_EXEC;
            byte_idx <= 2'd0;
          end
        end
        default: begin
          if (halt) begin
            state    <= S_IDLE;
            halted_q <= 1'b1;
          end else if (!mem_busy) begin // Store handshake done
            state <= S_FETCH;
            if (take_jump) pc <= {imm_hi, imm_lo};
          end
        end
      endcase
    end
  end

endmodule

/* rtl/reg_file.sv */
module reg_file (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [7:0]          instr,
  input  logic                rp_en,
  input  logic                reg_write_en,
  input  logic                load_en,
  input  i8080_pkg::alu_src_t alu_source,
  input  logic [7:0]          imm_lo,
  input  logic [7:0]          imm_hi,
  input  logic [7:0]          result,
  input  logic [7:0]          load_data,
  input  logic                mem_busy,
  output logic [7:0]          dst_val,
  output logic [7:0]          src_val,
  output logic [15:0]         pair_addr
);

  logic [7:0]  regs [8]; // B C D E H L (M) A
  logic [2:0]  dst_idx;
  logic [2:0]  hi_idx;
  logic [2:0]  lo_idx;
  logic        acc_dst;
  logic        pair_ok;
  logic        pair_wr;
  logic        skip_wr;
  logic [15:0] pair_val;
  logic [15:0] pair_next;

  // ALU group, rotates, STAX and LDAX all work on A
  assign acc_dst = instr[7] |
                   (instr[7:6] == 2'b00 && (instr[2:0] == 3'b111 || instr[2:0] == 3'b010));
  assign dst_idx = acc_dst ? 3'd7 : instr[5:3];
  assign dst_val = (dst_idx == 3'd6) ? 8'h00 : regs[dst_idx];
  assign src_val = (instr[2:0] == 3'd6) ? 8'h00 : regs[instr[2:0]];

  assign hi_idx    = {instr[5:4], 1'b0};
  assign lo_idx    = {instr[5:4], 1'b1};
  assign pair_ok   = (instr[5:4] != 2'b11); // No SP
  assign pair_val  = pair_ok ? {regs[hi_idx], regs[lo_idx]} : 16'h0000;
  assign pair_addr = pair_val;
  assign skip_wr   = (instr[7:6] == 2'b00) && (alu_source == i8080_pkg::ALU_SRC_REG); // DAA, CMA

  always_comb begin
    pair_next = pair_val;
    pair_wr   = 1'b0;
    if (rp_en && instr[1:0] == 2'b01 && !instr[3]) begin // LXI
      pair_next = {imm_hi, imm_lo};
      pair_wr   = pair_ok;
    end else if (rp_en && instr[1:0] == 2'b11) begin
      pair_next = instr[3] ? pair_val - 16'd1 : pair_val + 16'd1;
      pair_wr   = pair_ok;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 8; i++) regs[i] <= 8'h00;
    end else if (reg_write_en && !mem_busy) begin
      if (rp_en) begin
        if (pair_wr) begin
          regs[hi_idx] <= pair_next[15:8];
          regs[lo_idx] <= pair_next[7:0];
        end else if (load_en) begin
          regs[7] <= load_data; // LDAX
        end
      end else if (dst_idx != 3'd6 && !skip_wr) begin
        regs[dst_idx] <= result;
      end
    end
  end

endmodule

/* rtl/alu.sv */
module alu (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [7:0]          instr,
  input  logic [2:0]          alu_op,
  input  i8080_pkg::alu_src_t alu_source,
  input  logic                imm_pass_thru,
  input  logic                flag_write_en,
  input  logic                instr_ready,
  input  logic [7:0]          dst_val,
  input  logic [7:0]          src_val,
  input  logic [7:0]          imm_lo,
  input  logic [7:0]          load_data,
  output logic [7:0]          result,
  output i8080_pkg::flags_t   flags
);

  logic [7:0]        b;
  logic [8:0]        sum;
  i8080_pkg::flags_t nf;

  assign b = imm_pass_thru ? imm_lo : src_val;

  always_comb begin
    result = b; // Plain move by default
    nf     = flags;
    sum    = 9'h000;
    case (alu_source)
      i8080_pkg::ALU_SRC_REG, i8080_pkg::ALU_SRC_IMM: begin
        if (instr[7]) begin // Arithmetic group, A against b
          case (i8080_pkg::alu_op_t'(alu_op))
            i8080_pkg::ALU_ADD: sum = {1'b0, dst_val} + {1'b0, b};
            i8080_pkg::ALU_ADC: sum = {1'b0, dst_val} + {1'b0, b} + {8'h00, flags.cy};
            i8080_pkg::ALU_SBB: sum = {1'b0, dst_val} - {1'b0, b} - {8'h00, flags.cy};
            i8080_pkg::ALU_ANA: sum = {1'b0, dst_val & b};
            i8080_pkg::ALU_XRA: sum = {1'b0, dst_val ^ b};
            i8080_pkg::ALU_ORA: sum = {1'b0, dst_val | b};
            default:            sum = {1'b0, dst_val} - {1'b0, b}; // SUB, CMP
          endcase
          result = sum[7:0];
          nf.z   = (sum[7:0] == 8'h00);
          nf.cy  = sum[8]; // Borrow on subtract
        end else if (instr == 8'h37) begin
          nf.cy = 1'b1; // STC
        end else if (instr == 8'h3f) begin
          nf.cy = !flags.cy; // CMC
        end
      end
      i8080_pkg::ALU_SRC_MOVE: begin
        if (instr[7:6] == 2'b00 && instr[2:0] == 3'b111) begin
          case (instr[4:3])
            2'b00:   result = {dst_val[6:0], dst_val[7]};  // RLC
            2'b01:   result = {dst_val[0], dst_val[7:1]};  // RRC
            2'b10:   result = {dst_val[6:0], flags.cy};    // RAL
            default: result = {flags.cy, dst_val[7:1]};    // RAR
          endcase
          nf.cy = instr[3] ? dst_val[0] : dst_val[7];
        end else if (instr[7:6] == 2'b00 && instr[2:0] == 3'b010) begin
          result = load_data; // LDAX
        end
      end
      default: begin // INR, DCR leave CY alone
        result = instr[0] ? dst_val - 8'd1 : dst_val + 8'd1;
        nf.z   = (result == 8'h00);
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) flags <= '0;
    else if (instr_ready && flag_write_en) flags <= nf;
  end

endmodule

/* rtl/data_ram.sv */
`include "i8080_cfg.svh"

module data_ram (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        store_en,
  input  logic        load_en,
  input  logic [15:0] pair_addr,
  input  logic [7:0]  a_val,
  input  logic        st_ready,
  output logic [7:0]  load_data,
  output logic        st_valid,
  output logic [7:0]  st_addr,
  output logic [7:0]  st_data,
  output logic        mem_busy
);

  localparam int AW = $clog2(`I8080_DATA_DEPTH);

  logic [7:0]          mem [`I8080_DATA_DEPTH];
  i8080_pkg::store_t   live;
  i8080_pkg::store_t   held;
  i8080_pkg::store_t   cur;
  logic                held_valid;

  assign live      = {pair_addr[7:0], a_val};
  assign cur       = held_valid ? held : live; // Frozen while stalled
  assign st_valid  = store_en;
  assign st_addr   = cur.addr;
  assign st_data   = cur.data;
  assign mem_busy  = store_en && !st_ready;
  assign load_data = load_en ? mem[pair_addr[AW-1:0]] : 8'h00;

  always_ff @(posedge clk) begin
    if (store_en && st_ready) mem[cur.addr[AW-1:0]] <= cur.data;
    if (store_en && !held_valid) held <= live;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) held_valid <= 1'b0;
    else        held_valid <= store_en && !st_ready;
  end

endmodule

/* rtl/i8080_core.sv */
module i8080_core (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       prog_valid,
  input  logic [7:0] prog_data,
  output logic       prog_ready,
  input  logic       start,
  output logic       halted,
  output logic       st_valid,
  output logic [7:0] st_addr,
  output logic [7:0] st_data,
  input  logic       st_ready
);

  logic [7:0]          instr;
  logic [7:0]          imm_lo;
  logic [7:0]          imm_hi;
  logic                instr_ready;
  logic [1:0]          num_bytes;
  logic                halt;
  logic                load_en;
  logic                store_en;
  logic                imm_pass_thru;
  logic                rp_en;
  logic                reg_write_en;
  logic                flag_write_en;
  i8080_pkg::alu_src_t alu_source;
  logic [2:0]          alu_op;
  logic [7:0]          dst_val;
  logic [7:0]          src_val;
  logic [15:0]         pair_addr;
  logic [7:0]          result;
  i8080_pkg::flags_t   flags;
  logic [7:0]          load_data;
  logic                mem_busy;

  control u_control (
    .instr_ready, .instr, .num_bytes, .halt, .load_en, .store_en, .imm_pass_thru,
    .rp_en, .reg_write_en, .flag_write_en,
    .pchl       (), // PCHL runs as a NOP
    .alu_source, .alu_op
  );

  instr_fetch u_instr_fetch (
    .clk, .rst_n, .start, .prog_valid, .prog_data, .prog_ready, .halt, .mem_busy,
    .flags, .instr, .imm_lo, .imm_hi, .instr_ready, .num_bytes, .halted
  );

  reg_file u_reg_file (
    .clk, .rst_n, .instr, .rp_en, .reg_write_en, .load_en, .alu_source, .imm_lo,
    .imm_hi, .result, .load_data, .mem_busy, .dst_val, .src_val, .pair_addr
  );

  alu u_alu (
    .clk, .rst_n, .instr, .alu_op, .alu_source, .imm_pass_thru, .flag_write_en,
    .instr_ready, .dst_val, .src_val, .imm_lo, .load_data, .result, .flags
  );

  data_ram u_data_ram (
    .clk, .rst_n, .store_en, .load_en, .pair_addr,
    .a_val     (dst_val), // A for STAX
    .st_ready, .load_data, .st_valid, .st_addr, .st_data, .mem_busy
  );

endmodule

/* tests/tb_i8080_core.sv */
`include "i8080_cfg.svh"

module tb_i8080_core;

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;

  logic       clk;
  logic       rst_n;
  logic       prog_valid;
  logic [7:0] prog_data;
  logic       prog_ready;
  logic       start;
  logic       halted;
  logic       st_valid;
  logic [7:0] st_addr;
  logic [7:0] st_data;
  logic       st_ready;

  logic [31:0]       lfsr;
  logic [7:0]        prog [$];
  i8080_pkg::store_t exp_st [$];
  i8080_pkg::store_t got_st [$];
  i8080_pkg::store_t pend;       // Entry seen stalled on the last negedge
  logic              pend_valid;
  logic              stall_en;
  logic              next_ready;
  logic [7:0]        st_ptr;     // Where the next STAX D lands
  int                errors;
  int                cycles;
  int                cycle_limit;

  i8080_core dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .prog_valid (prog_valid),
    .prog_data  (prog_data),
    .prog_ready (prog_ready),
    .start      (start),
    .halted     (halted),
    .st_valid   (st_valid),
    .st_addr    (st_addr),
    .st_data    (st_data),
    .st_ready   (st_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [7:0] lfsr_bits(input int n);
    logic [7:0] v;
    int         i;
    v = 8'h00;
    for (i = 0; i < n; i++) begin
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0000_0000);
      v    = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  // 8080 arithmetic rules, returns {CY, result}
  function automatic logic [8:0] alu_rule(input logic [2:0] op, input logic [7:0] a,
                                          input logic [7:0] b, input logic cin);
    int x;
    int y;
    int r;
    x = a;
    y = b;
    case (op)
      3'd0:       r = x + y;
      3'd1:       r = x + y + cin;
      3'd2, 3'd7: r = x - y;      // Borrow when the difference goes negative
      3'd3:       r = x - y - cin;
      3'd4:       r = a & b;
      3'd5:       r = a ^ b;
      default:    r = a | b;
    endcase
    return {(r > 255) || (r < 0), r[7:0]};
  endfunction

  task automatic compare_store(input i8080_pkg::store_t want, input i8080_pkg::store_t seen,
                               input string what);
    if (seen !== want) begin
      errors++;
      $display("MISMATCH at %0t: %s store expected addr %02h data %02h, got addr %02h data %02h",
               $time, what, want.addr, want.data, seen.addr, seen.data);
    end
  endtask

  task automatic compare_flags(input i8080_pkg::flags_t want, input i8080_pkg::flags_t seen,
                               input string what);
    if (seen !== want) begin
      errors++;
      $display("MISMATCH at %0t: %s flags expected z=%b cy=%b, got z=%b cy=%b",
               $time, what, want.z, want.cy, seen.z, seen.cy);
    end
  endtask

  task automatic emit(input logic [7:0] b);
    prog.push_back(b);
  endtask

  task automatic imm8(input logic [7:0] op, input logic [7:0] d);
    emit(op);
    emit(d);
  endtask

  task automatic imm16(input logic [7:0] op, input logic [7:0] lo, input logic [7:0] hi);
    emit(op);
    emit(lo);
    emit(hi);
  endtask

  task automatic begin_program(input logic [7:0] base);
    prog.delete();
    exp_st.delete();
    st_ptr = base;
    imm16(8'h11, base, 8'h00); // LXI D points the store stream
  endtask

  task automatic store_a(input logic [7:0] val);
    emit(8'h12); // STAX D
    emit(8'h13); // INX D
    exp_st.push_back({st_ptr, val});
    st_ptr++;
  endtask

  // Conditional jump that stores mark when not taken and mark+1 when taken
  task automatic branch_marker(input logic [7:0] jop, input logic [7:0] mark);
    int taken_at;
    int join_at;
    imm16(jop, 8'h00, 8'h00);
    taken_at = prog.size() - 2;
    imm8(8'h3E, mark);
    imm16(8'hC3, 8'h00, 8'h00);
    join_at = prog.size() - 2;
    prog[taken_at] = 8'(prog.size());
    imm8(8'h3E, mark | 8'h01);
    prog[join_at] = 8'(prog.size());
    emit(8'h12);
    emit(8'h13);
  endtask

  task automatic run_program();
    emit(8'h76); // HLT
    if (prog.size() > `I8080_PROG_DEPTH) begin
      errors++;
      $display("Program of %0d bytes does not fit the program memory", prog.size());
    end
    got_st.delete();
    cycle_limit += 40 * prog.size();
    foreach (prog[i]) begin
      prog_valid = 1'b1;
      prog_data  = prog[i];
      @(negedge clk);
      while (!prog_ready) @(negedge clk);
      @(posedge clk);
      #DRIVE_DLY;
    end
    prog_valid = 1'b0;
    start      = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    start = 1'b0;
    @(negedge clk);
    while (!halted) @(negedge clk);
    @(negedge clk);
    if (!prog_ready) begin
      errors++;
      $display("prog_ready did not return high after HLT at %0t", $time);
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic check_stores(input string what);
    if (got_st.size() != exp_st.size()) begin
      errors++;
      $display("%s: expected %0d stores but saw %0d", what, exp_st.size(), got_st.size());
    end
    foreach (exp_st[i]) begin
      if (i < got_st.size()) compare_store(exp_st[i], got_st[i], what);
    end
  endtask

  task automatic move_store_test();
    logic [7:0] k1;
    logic [7:0] k2;
    logic [7:0] k3;
    k1 = lfsr_bits(8);
    k2 = lfsr_bits(8);
    k3 = lfsr_bits(8);
    begin_program(8'h10);
    imm8(8'h06, k1);            // MVI B
    emit(8'h48);                // MOV C,B
    emit(8'h79);                // MOV A,C
    store_a(k1);
    imm8(8'h26, k2);            // MVI H
    emit(8'h6C);                // MOV L,H
    emit(8'h7D);                // MOV A,L
    store_a(k2);
    imm16(8'h01, 8'h80, 8'h00); // LXI B
    imm8(8'h3E, k3);
    emit(8'h02);                // STAX B
    exp_st.push_back({8'h80, k3});
    emit(8'h78);                // MOV A,B
    store_a(8'h00);
    run_program();
    check_stores("move");
  endtask

  task automatic alu_test();
    logic [7:0] a;
    logic [7:0] b;
    logic       cin;
    logic [8:0] r;
    logic [2:0] op;
    int         k;
    begin_program(8'h20);
    for (k = 0; k < 16; k++) begin
      op  = k[3:1];
      a   = lfsr_bits(8);
      b   = lfsr_bits(8);
      cin = (lfsr_bits(1) != 8'h00);
      imm8(8'h3E, a);
      emit(8'h37);                        // STC
      if (!cin) emit(8'h3F);              // CMC
      if (k[0]) begin
        imm8({2'b11, op, 3'b110}, b);     // Immediate form
      end else begin
        imm8(8'h06, b);
        emit(8'h37);
        if (!cin) emit(8'h3F);
        emit({2'b10, op, 3'b000});        // Register form on B
      end
      r = alu_rule(op, a, b, cin);
      store_a((op == 3'd7) ? a : r[7:0]); // CMP and CPI keep A
    end
    run_program();
    check_stores("alu");
  endtask

  task automatic flag_jump_test();
    logic [7:0]        a;
    logic [7:0]        b;
    logic [8:0]        r;
    logic [2:0]        op;
    i8080_pkg::flags_t want_fl [6];
    i8080_pkg::flags_t seen_fl;
    int                k;
    begin_program(8'h40);
    for (k = 0; k < 6; k++) begin
      op = (k % 3 == 0) ? 3'd0 : ((k % 3 == 1) ? 3'd2 : 3'd7); // ADD, SUB, CMP
      a  = lfsr_bits(8);
      b  = lfsr_bits(8);
      if (lfsr_bits(1) != 8'h00) b = (op == 3'd0) ? -a : a; // Zero result
      imm8(8'h3E, a);
      imm8(8'h06, b);
      emit({2'b10, op, 3'b000});
      r = alu_rule(op, a, b, 1'b0);
      want_fl[k].z  = (r[7:0] == 8'h00);
      want_fl[k].cy = r[8];
      branch_marker(k[0] ? 8'hC2 : 8'hCA, 8'h10); // JNZ or JZ
      branch_marker(k[1] ? 8'hD2 : 8'hDA, 8'h20); // JNC or JC
    end
    run_program();
    if (got_st.size() != 12) begin
      errors++;
      $display("branch: expected 12 marker stores but saw %0d", got_st.size());
    end
    for (k = 0; k < 6 && 2 * k + 1 < got_st.size(); k++) begin
      seen_fl.z  = got_st[2 * k].data[0] ^ k[0];
      seen_fl.cy = got_st[2 * k + 1].data[0] ^ k[1];
      compare_flags(want_fl[k], seen_fl, "branch");
    end
  endtask

  task automatic incdec_rotate_test();
    logic [7:0] a;
    logic [7:0] n;
    logic [7:0] h;
    logic       cy;
    begin_program(8'h60);
    imm8(8'h3E, 8'hFF);
    emit(8'h3C);                // INR A
    store_a(8'h00);
    emit(8'h3D);                // DCR A
    store_a(8'hFF);
    a = lfsr_bits(8);
    imm8(8'h06, a);
    emit(8'h04);                // INR B
    emit(8'h05);                // DCR B
    emit(8'h05);
    emit(8'h78);
    store_a(a - 8'd1);
    h = lfsr_bits(8);
    imm16(8'h01, 8'hFF, h);     // LXI B
    emit(8'h03);                // INX B, carry into B
    emit(8'h78);
    store_a(h + 8'd1);
    emit(8'h79);
    store_a(8'h00);
    emit(8'h0B);                // DCX B
    emit(8'h78);
    store_a(h);
    emit(8'h79);
    store_a(8'hFF);
    a = lfsr_bits(8);
    imm8(8'h3E, a);
    emit(8'h37);
    emit(8'h07);                // RLC
    cy = a[7];
    a  = {a[6:0], a[7]};
    store_a(a);
    emit(8'h17);                // RAL
    n  = {a[6:0], cy};
    cy = a[7];
    a  = n;
    store_a(a);
    emit(8'h3F);                // CMC
    emit(8'h1F);                // RAR
    n  = {!cy, a[7:1]};
    a  = n;
    store_a(a);
    emit(8'h37);                // STC
    emit(8'h17);
    a = {a[6:0], 1'b1};
    store_a(a);
    emit(8'h0F);                // RRC
    a = {a[0], a[7:1]};
    store_a(a);
    run_program();
    check_stores("inc/dec/rotate");
  endtask

  task automatic backpressure_test();
    logic [7:0] v;
    int         k;
    begin_program(8'hA0);
    for (k = 0; k < 8; k++) begin
      v = lfsr_bits(8);
      imm8(8'h3E, v);
      store_a(v);
    end
    imm16(8'h01, 8'hC0, 8'h00);
    emit(8'h02);                // STAX B right before HLT
    exp_st.push_back({8'hC0, v});
    stall_en = 1'b1;
    run_program();
    stall_en = 1'b0;
    check_stores("back-pressure");
  endtask

  task automatic ldax_test();
    logic [7:0] r1;
    logic [7:0] r2;
    r1 = lfsr_bits(8);
    r2 = lfsr_bits(8);
    begin_program(8'hD0);
    imm8(8'h3E, r1);
    store_a(r1);
    imm8(8'h3E, r2);
    store_a(r2);
    imm16(8'h01, 8'hD0, 8'h00);
    imm8(8'h3E, ~r1);
    emit(8'h0A);                // LDAX B
    store_a(r1);
    emit(8'h03);
    emit(8'h0A);
    store_a(r2);
    emit(8'h09);                // DAD B
    emit(8'h2F);                // CMA
    emit(8'h27);                // DAA
    emit(8'hE9);                // PCHL
    store_a(r2);
    emit(8'h0A);                // BC must be untouched by DAD
    store_a(r2);
    run_program();
    check_stores("ldax");
  endtask

  // Store stream monitor, also picks the next st_ready
  always @(negedge clk) begin
    if (rst_n && st_valid) begin
      if (pend_valid && {st_addr, st_data} != pend) begin
        errors++;
        $display("Store address or data changed while stalled at %0t", $time);
      end
      if (halted) begin
        errors++;
        $display("Store seen while halted at %0t", $time);
      end
      if (st_ready) got_st.push_back({st_addr, st_data});
      pend       = {st_addr, st_data};
      pend_valid = !st_ready;
    end else begin
      pend_valid = 1'b0;
    end
    next_ready = 1'b1;
    if (stall_en === 1'b1) next_ready = (lfsr_bits(2) == 8'h00); // Mostly stalled
  end

  always @(posedge clk) begin
    #DRIVE_DLY;
    st_ready = next_ready;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the core never reached HLT", cycle_limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    lfsr        = 32'h5ac0_b35c;
    errors      = 0;
    cycles      = 0;
    cycle_limit = 2000;
    pend_valid  = 1'b0;
    stall_en    = 1'b0;
    next_ready  = 1'b1;
    rst_n       = 1'b0;
    prog_valid  = 1'b0;
    prog_data   = 8'h00;
    start       = 1'b0;
    st_ready    = 1'b1;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    @(negedge clk);
    if (!prog_ready || halted || st_valid) begin
      errors++;
      $display("Core outputs are not idle after reset");
    end
    @(posedge clk);
    #DRIVE_DLY;
    move_store_test();
    alu_test();
    flag_jump_test();
    incdec_rotate_test();
    backpressure_test();
    ldax_test();
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* i8080_core.f */
+incdir+include
rtl/i8080_pkg.sv
rtl/control.sv
rtl/instr_fetch.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/data_ram.sv
rtl/i8080_core.sv
tests/tb_i8080_core.sv

/* Bender.yml */
package:
  name: i8080_core

sources:
  - include_dirs:
      - include
    files:
      - rtl/i8080_pkg.sv
      - rtl/control.sv
      - rtl/instr_fetch.sv
      - rtl/reg_file.sv
      - rtl/alu.sv
      - rtl/data_ram.sv
      - rtl/i8080_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_i8080_core.sv
